/* Bender.yml */
package:
  name: md_cart

sources:
  - include_dirs:
      - .
    files:
      - md_cart_pkg.sv
      - download_monitor.sv
      - serial_matcher.sv
      - quirk_collector.sv
      - region_select.sv
      - cheat_loader.sv
      - md_cart_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_md_cart.sv

/* cheat_loader.sv */
`timescale 1ns/1ps
`include "md_cart_defines.svh"

module cheat_loader (
	input  logic                  clk_sys,
	input  logic                  RESET,
	input  logic                  code_download,
	input  logic                  ld_wr,
	input  logic [`MD_ADDR_W-1:0] ld_addr,
	input  logic [`MD_DATA_W-1:0] ld_data,
	output logic [`MD_GG_W-1:0]   gg_code,
	output logic                  gg_code_stb,
	output logic                  gg_reset
);

	// {flags, address, compare, replace}, 32 bits each
	logic [`MD_GG_W-2:0] code_q;
	logic                wr_en;

	assign wr_en   = code_download & ld_wr;
	assign gg_code = {gg_code_stb, code_q}; // Top bit clocks the code in

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			gg_code_stb <= 1'b0;
			gg_reset    <= 1'b0;
		end else begin
			gg_code_stb <= wr_en && (ld_addr[3:0] == 4'd14); // Record complete
			gg_reset    <= wr_en && (ld_addr == '0);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Low word first within each field
	always_ff @(posedge clk_sys) begin
		if (wr_en) begin
			case (ld_addr[3:0])
				4'd0:  code_q[111:96]  <= ld_data; // Flags
				4'd2:  code_q[127:112] <= ld_data;
				4'd4:  code_q[79:64]   <= ld_data; // Address
				4'd6:  code_q[95:80]   <= ld_data;
				4'd8:  code_q[47:32]   <= ld_data; // Compare
				4'd10: code_q[63:48]   <= ld_data;
				4'd12: code_q[15:0]    <= ld_data; // Replace
				4'd14: code_q[31:16]   <= ld_data;
				default: ;
			endcase
		end
	end

endmodule

/* download_monitor.sv */
`timescale 1ns/1ps
`include "md_cart_defines.svh"

module download_monitor (
	input  logic                    clk_sys,
	input  logic                    RESET,
	input  logic                    cart_download,
	input  logic                    ld_wr,
	input  logic [`MD_ADDR_W-1:0]   ld_addr,
	input  logic [`MD_DATA_W-1:0]   ld_data,
	output logic                    dl_start,
	output logic                    dl_end,
	output md_cart_pkg::serial_t    serial,
	output logic                    serial_chk,
	output logic [`MD_ADDR_W-1:0]   rom_size
);

	logic                  dl_q;
	logic [`MD_ADDR_W-1:0] last_addr; // Address of the latest ROM word
	logic                  wr_en;

	assign wr_en = cart_download & ld_wr;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			dl_q       <= 1'b0;
			dl_start   <= 1'b0;
			dl_end     <= 1'b0;
			serial_chk <= 1'b0;
			rom_size   <= '0;
		end else begin
			dl_q       <= cart_download;
			dl_start   <= cart_download & ~dl_q;
			dl_end     <= ~cart_download & dl_q;
			serial_chk <= wr_en && (ld_addr == `MD_SERIAL_CHECK);
			if (dl_end)
				rom_size <= last_addr;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Serial capture, words arrive with the bytes swapped
	always_ff @(posedge clk_sys) begin
		if (wr_en) begin
			last_addr <= ld_addr;
			case (ld_addr)
				`MD_SERIAL_FIRST:         serial[63:56] <= ld_data[15:8];
				`MD_SERIAL_FIRST + 25'd2: serial[55:40] <= {ld_data[7:0], ld_data[15:8]};
				`MD_SERIAL_FIRST + 25'd4: serial[39:24] <= {ld_data[7:0], ld_data[15:8]};
				`MD_SERIAL_FIRST + 25'd6: serial[23:8]  <= {ld_data[7:0], ld_data[15:8]};
				`MD_SERIAL_LAST:          serial[7:0]   <= ld_data[7:0];
				default: ;
			endcase
		end
	end

	// Loader only writes whole words
	a_even_addr: assert property (@(posedge clk_sys) disable iff (RESET)
		$rose(ld_wr) |-> !ld_addr[0]);

endmodule

/* md_cart.f */
+incdir+.
md_cart_pkg.sv
download_monitor.sv
serial_matcher.sv
quirk_collector.sv
region_select.sv
cheat_loader.sv
md_cart_top.sv
tb_md_cart.sv

/* md_cart_defines.svh */
`ifndef MD_CART_DEFINES_SVH
`define MD_CART_DEFINES_SVH

// Loader bus widths
`define MD_ADDR_W 25
`define MD_DATA_W 16

// Serial number words in the cartridge header
`define MD_SERIAL_FIRST 25'h182
`define MD_SERIAL_LAST  25'h18A
`define MD_SERIAL_CHECK 25'h18C // First write past the serial

// Region letters
`define MD_REGION_ADDR_A 25'h1F0
`define MD_REGION_ADDR_B 25'h1F2

`define MD_HDR_END 25'h200 // Header fully received

`define MD_N_SERIALS 8
`define MD_GG_W      129 // Strobe bit plus 128 bits of code

`endif

/* md_cart_pkg.sv */
`include "md_cart_defines.svh"

package md_cart_pkg;

	// Console region, same encoding as the region menu
	typedef enum logic [1:0] {
		JP = 2'd0,
		US = 2'd1,
		EU = 2'd2
	} region_t;

	// Search order for the automatic region
	typedef enum logic [1:0] {
		US_EU_JP = 2'd0,
		EU_US_JP = 2'd1,
		US_JP_EU = 2'd2,
		JP_US_EU = 2'd3
	} prio_t;

	typedef logic [63:0] serial_t; // Eight ASCII chars, first one on top

	typedef enum logic [2:0] {
		SRAM   = 3'd0,
		EEPROM = 3'd1,
		NORAM  = 3'd2,
		FIFO   = 3'd3,
		PIER   = 3'd4,
		SVP    = 3'd5,
		FMBUSY = 3'd6 // Highest index, sizes the quirk vector
	} quirk_idx_t;

	typedef struct packed {
		serial_t    serial;
		quirk_idx_t quirk;
	} quirk_entry_t;

	// Known titles needing a compatibility quirk
	localparam quirk_entry_t quirk_table [`MD_N_SERIALS] = '{
		'{serial: "T-081276", quirk: SRAM},
		'{serial: "MK-1215 ", quirk: EEPROM},
		'{serial: "G-4060  ", quirk: EEPROM},
		'{serial: "T-113016", quirk: NORAM},  // Fake RAM check
		'{serial: "T-89016 ", quirk: FIFO},
		'{serial: "T-574023", quirk: PIER},
		'{serial: "MK-1229 ", quirk: SVP},
		'{serial: "T-35036 ", quirk: FMBUSY}
	};

endpackage

/* md_cart_top.sv */
`timescale 1ns/1ps
`include "md_cart_defines.svh"

module md_cart_top (
	input  logic                         clk_sys,
	input  logic                         RESET,
	input  logic                         cart_download,
	input  logic                         code_download,
	input  logic                         ld_wr,
	input  logic [`MD_ADDR_W-1:0]        ld_addr,
	input  logic [`MD_DATA_W-1:0]        ld_data,
	input  logic                         region_auto,
	input  logic [1:0]                   region_prio,
	output md_cart_pkg::region_t         region_req,
	output logic                         region_set,
	output logic [md_cart_pkg::FMBUSY:0] quirks,
	output logic [`MD_ADDR_W-1:0]        rom_size,
	output logic [`MD_GG_W-1:0]          gg_code,
	output logic                         gg_code_stb,
	output logic                         gg_reset
);

	logic                     dl_start;
	md_cart_pkg::serial_t     serial;
	logic                     serial_chk;
	logic [`MD_N_SERIALS-1:0] hit;

	download_monitor u_monitor (
		.clk_sys(clk_sys), .RESET(RESET), .cart_download(cart_download),
		.ld_wr(ld_wr), .ld_addr(ld_addr), .ld_data(ld_data),
		.dl_start(dl_start),
		.dl_end(), // Only drives the size latch inside the monitor
		.serial(serial), .serial_chk(serial_chk), .rom_size(rom_size)
	);

	//////////////////////////////////////////////////////////////////////
	// One matcher per known title
	for (genvar i = 0; i < `MD_N_SERIALS; i++) begin : g_match
		serial_matcher #(.ENTRY(md_cart_pkg::quirk_table[i])) u_match (
			.clk_sys(clk_sys), .RESET(RESET),
			.serial(serial), .serial_chk(serial_chk), .hit(hit[i])
		);
	end

	quirk_collector u_quirks (
		.clk_sys(clk_sys), .RESET(RESET), .dl_start(dl_start),
		.hit(hit), .quirks(quirks)
	);

	region_select u_region (
		.clk_sys(clk_sys), .RESET(RESET), .cart_download(cart_download),
		.ld_wr(ld_wr), .ld_addr(ld_addr), .ld_data(ld_data),
		.region_auto(region_auto), .region_prio(region_prio),
		.region_req(region_req), .region_set(region_set)
	);

	cheat_loader u_cheat (
		.clk_sys(clk_sys), .RESET(RESET), .code_download(code_download),
		.ld_wr(ld_wr), .ld_addr(ld_addr), .ld_data(ld_data),
		.gg_code(gg_code), .gg_code_stb(gg_code_stb), .gg_reset(gg_reset)
	);

endmodule

/* quirk_collector.sv */
`timescale 1ns/1ps
`include "md_cart_defines.svh"

module quirk_collector (
	input  logic                            clk_sys,
	input  logic                            RESET,
	input  logic                            dl_start,
	input  logic [`MD_N_SERIALS-1:0]        hit,
	output logic [md_cart_pkg::FMBUSY:0]    quirks // One flag per quirk_idx_t value
);

	logic [md_cart_pkg::FMBUSY:0] set_vec;

	//////////////////////////////////////////////////////////////////////
	// Table entry to quirk flag
	always_comb begin
		set_vec = '0;
		for (int i = 0; i < `MD_N_SERIALS; i++) begin
			if (hit[i])
				set_vec[md_cart_pkg::quirk_table[i].quirk] = 1'b1;
		end
	end

	// Sticky until the next cartridge
	always_ff @(posedge clk_sys) begin
		if (RESET)
			quirks <= '0;
		else if (dl_start)
			quirks <= '0;
		else
			quirks <= quirks | set_vec;
	end

	// Table serials are distinct so only one matcher can fire
	a_one_hit: assert property (@(posedge clk_sys) disable iff (RESET)
		$onehot0(hit));

endmodule

/* region_select.sv */
`timescale 1ns/1ps
`include "md_cart_defines.svh"

module region_select (
	input  logic                  clk_sys,
	input  logic                  RESET,
	input  logic                  cart_download,
	input  logic                  ld_wr,
	input  logic [`MD_ADDR_W-1:0] ld_addr,
	input  logic [`MD_DATA_W-1:0] ld_data,
	input  logic                  region_auto,
	input  logic [1:0]            region_prio,
	output md_cart_pkg::region_t  region_req,
	output logic                  region_set
);

	logic                 dl_q;
	logic                 hdr_ready;
	logic                 hdr_ready_q;
	logic                 hdr_j;
	logic                 hdr_u;
	logic                 hdr_e;
	logic                 wr_en;
	md_cart_pkg::prio_t   prio;
	md_cart_pkg::region_t pick;

	assign wr_en = cart_download & ld_wr;
	assign prio  = md_cart_pkg::prio_t'(region_prio);

	// Returns {J, U, E} for one header character
	function automatic logic [2:0] letter_flags(input logic [7:0] c);
		logic [2:0] f;
		f = 3'b000;
		if (c == "J")
			f[2] = 1'b1;
		else if (c == "U")
			f[1] = 1'b1;
		else if (c >= "0" && c <= "Z")
			f[0] = 1'b1; // Anything else counts as Europe
		return f;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Priority resolve, falls back to the first region of the order
	always_comb begin
		case (prio)
			md_cart_pkg::US_EU_JP: pick = hdr_u ? md_cart_pkg::US : hdr_e ? md_cart_pkg::EU :
				hdr_j ? md_cart_pkg::JP : md_cart_pkg::US;
			md_cart_pkg::EU_US_JP: pick = hdr_e ? md_cart_pkg::EU : hdr_u ? md_cart_pkg::US :
				hdr_j ? md_cart_pkg::JP : md_cart_pkg::EU;
			md_cart_pkg::US_JP_EU: pick = hdr_u ? md_cart_pkg::US : hdr_j ? md_cart_pkg::JP :
				hdr_e ? md_cart_pkg::EU : md_cart_pkg::US;
			default:               pick = hdr_j ? md_cart_pkg::JP : hdr_u ? md_cart_pkg::US :
				hdr_e ? md_cart_pkg::EU : md_cart_pkg::JP;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			dl_q                  <= 1'b0;
			hdr_ready             <= 1'b0;
			hdr_ready_q           <= 1'b0;
			{hdr_j, hdr_u, hdr_e} <= 3'b000;
			region_req            <= md_cart_pkg::JP;
			region_set            <= 1'b0;
		end else begin
			dl_q        <= cart_download;
			hdr_ready_q <= hdr_ready;

			if (cart_download & ~dl_q)
				{hdr_j, hdr_u, hdr_e} <= 3'b000; // New cartridge
			if (~cart_download & dl_q)
				hdr_ready <= 1'b0;

			if (wr_en) begin
				if (ld_addr == `MD_REGION_ADDR_A)
					{hdr_j, hdr_u, hdr_e} <= {hdr_j, hdr_u, hdr_e} |
						letter_flags(ld_data[15:8]) | letter_flags(ld_data[7:0]);
				if (ld_addr == `MD_REGION_ADDR_B)
					{hdr_j, hdr_u, hdr_e} <= {hdr_j, hdr_u, hdr_e} | letter_flags(ld_data[7:0]);
				if (ld_addr == `MD_HDR_END)
					hdr_ready <= 1'b1;
			end

			if (hdr_ready & ~hdr_ready_q & region_auto) begin
				region_req <= pick;
				region_set <= 1'b1;
			end
			if (~hdr_ready & hdr_ready_q)
				region_set <= 1'b0; // Download finished
		end
	end

endmodule

/* serial_matcher.sv */
`timescale 1ns/1ps

module serial_matcher #(
	parameter md_cart_pkg::quirk_entry_t ENTRY = '0
) (
	input  logic                 clk_sys,
	input  logic                 RESET,
	input  md_cart_pkg::serial_t serial,
	input  logic                 serial_chk,
	output logic                 hit
);

	localparam md_cart_pkg::serial_t KEY = ENTRY.serial;

	logic match;

	// Full 64-bit compare against this entry
	assign match = (serial == KEY);

	always_ff @(posedge clk_sys) begin
		if (RESET)
			hit <= 1'b0;
		else
			hit <= serial_chk & match; // One cycle pulse per check
	end

endmodule

/* tb_md_cart.sv */
`timescale 1ns/1ps
`include "md_cart_defines.svh"

module tb_md_cart;

	localparam int CYCLE_LIMIT = 13 * 300 + 100; // 13 records at 300 cycles, plus margin

	typedef struct packed {
		logic [63:0]          serial;
		logic [23:0]          letters; // Bytes 0x1F0, 0x1F1 and 0x1F2
		logic                 auto_en;
		md_cart_pkg::prio_t   prio;
		md_cart_pkg::region_t exp_req;
		logic                 exp_set;
		logic [6:0]           exp_quirks;
		logic [`MD_ADDR_W-1:0] rom_end; // Last word address written
	} cart_row_t;

	typedef struct packed {
		logic [`MD_ADDR_W-1:0] base;
		logic [127:0]          words; // Word at offset 2k sits in bits 16k+15:16k
		logic [`MD_GG_W-1:0]   exp_code;
	} cheat_row_t;

	// Row 7 has auto off, its expected region is never looked at
	localparam cart_row_t CARTS [10] = '{
		'{"T-081276", "JUE", 1'b1, md_cart_pkg::US_EU_JP, md_cart_pkg::US, 1'b1, 7'h01, 25'h202},
		'{"MK-1215 ", "J  ", 1'b1, md_cart_pkg::US_EU_JP, md_cart_pkg::JP, 1'b1, 7'h02, 25'h20A},
		'{"G-4060  ", "E  ", 1'b1, md_cart_pkg::JP_US_EU, md_cart_pkg::EU, 1'b1, 7'h02, 25'h210},
		'{"T-99999 ", "   ", 1'b1, md_cart_pkg::EU_US_JP, md_cart_pkg::EU, 1'b1, 7'h00, 25'h204},
		'{"T-113016", "JU ", 1'b1, md_cart_pkg::JP_US_EU, md_cart_pkg::JP, 1'b1, 7'h04, 25'h21E},
		'{"T-89016 ", "UE ", 1'b1, md_cart_pkg::EU_US_JP, md_cart_pkg::EU, 1'b1, 7'h08, 25'h206},
		'{"T-574023", "4  ", 1'b1, md_cart_pkg::US_JP_EU, md_cart_pkg::EU, 1'b1, 7'h10, 25'h208},
		'{"MK-1229 ", "JUE", 1'b0, md_cart_pkg::US_JP_EU, md_cart_pkg::JP, 1'b0, 7'h20, 25'h20C},
		'{"T-35036 ", "ju ", 1'b1, md_cart_pkg::US_JP_EU, md_cart_pkg::US, 1'b1, 7'h40, 25'h212},
		'{"T-35037 ", "JE ", 1'b1, md_cart_pkg::US_EU_JP, md_cart_pkg::EU, 1'b1, 7'h00, 25'h202}
	};

	// Expected code is {strobe, flags, address, compare, replace}
	localparam cheat_row_t CHEATS [3] = '{
		'{25'h000, 128'h2222_4E71_1111_4E75_0001_2345_8000_0001,
			129'h1_8000_0001_0001_2345_1111_4E75_2222_4E71},
		'{25'h010, 128'h0000_ABCD_0000_1234_00FF_FF10_0000_0003,
			129'h1_0000_0003_00FF_FF10_0000_1234_0000_ABCD},
		'{25'h120, 128'hF00D_CAFE_BEEF_DEAD_2468_1357_A5A5_5A5A,
			129'h1_A5A5_5A5A_2468_1357_BEEF_DEAD_F00D_CAFE}
	};

	logic                  clk_sys;
	logic                  RESET;
	logic                  cart_download;
	logic                  code_download;
	logic                  ld_wr;
	logic [`MD_ADDR_W-1:0] ld_addr;
	logic [`MD_DATA_W-1:0] ld_data;
	logic                  region_auto;
	logic [1:0]            region_prio;
	md_cart_pkg::region_t  region_req;
	logic                  region_set;
	logic [6:0]            quirks;
	logic [`MD_ADDR_W-1:0] rom_size;
	logic [`MD_GG_W-1:0]   gg_code;
	logic                  gg_code_stb;
	logic                  gg_reset;
	int                    errors;
	int                    cycle_count;

	md_cart_top dut (
		.clk_sys(clk_sys), .RESET(RESET), .cart_download(cart_download),
		.code_download(code_download), .ld_wr(ld_wr), .ld_addr(ld_addr), .ld_data(ld_data),
		.region_auto(region_auto), .region_prio(region_prio), .region_req(region_req),
		.region_set(region_set), .quirks(quirks), .rom_size(rom_size), .gg_code(gg_code),
		.gg_code_stb(gg_code_stb), .gg_reset(gg_reset)
	);

	always #20 clk_sys = ~clk_sys;

	//////////////////////////////////////////////////////////////////////
	// Loader stream helpers

	// Word as the loader sends it, header fields over random fill
	function automatic logic [15:0] header_word(input logic [`MD_ADDR_W-1:0] addr,
			input cart_row_t row, input logic [15:0] rnd);
		case (addr)
			`MD_SERIAL_FIRST:         return {row.serial[63:56], rnd[7:0]};
			`MD_SERIAL_FIRST + 25'd2: return {row.serial[47:40], row.serial[55:48]}; // Swapped
			`MD_SERIAL_FIRST + 25'd4: return {row.serial[31:24], row.serial[39:32]};
			`MD_SERIAL_FIRST + 25'd6: return {row.serial[15:8], row.serial[23:16]};
			`MD_SERIAL_LAST:          return {rnd[15:8], row.serial[7:0]};
			`MD_REGION_ADDR_A:        return row.letters[23:8];
			`MD_REGION_ADDR_B:        return {rnd[15:8], row.letters[7:0]};
			default:                  return rnd;
		endcase
	endfunction

	task automatic report_mismatch(input string name, input logic [128:0] got,
			input logic [128:0] exp);
		errors++;
		$display("FAILED %s: got 0x%0h, expected 0x%0h at time %0t", name, got, exp, $time);
	endtask

	// Called 2 ns after an edge, returns 2 ns after the sampling edge
	task automatic write_word(input logic [`MD_ADDR_W-1:0] addr, input logic [15:0] data);
		ld_wr   = 1'b1;
		ld_addr = addr;
		ld_data = data;
		@(posedge clk_sys);
		#2;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk_sys);
			#2;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// One cartridge download with its checks
	task automatic run_cart(input cart_row_t row);
		logic [15:0] data;
		cart_download = 1'b1;
		region_auto   = row.auto_en;
		region_prio   = row.prio;
		idle_cycles(2);
		if (quirks !== 7'h00)
			report_mismatch("quirks", quirks, 7'h00); // Cleared by the new download
		for (int a = 0; a <= row.rom_end; a += 2) begin
			data = header_word(25'(a), row, 16'($urandom()));
			write_word(25'(a), data);
			if (gg_reset !== 1'b0)
				report_mismatch("gg_reset", gg_reset, 1'b0);
			if (a == `MD_SERIAL_CHECK + 2 && quirks !== 7'h00)
				report_mismatch("quirks", quirks, 7'h00); // Still in the pipeline
			if (a == `MD_SERIAL_CHECK + 4 && quirks !== row.exp_quirks)
				report_mismatch("quirks", quirks, row.exp_quirks);
			if (a == `MD_HDR_END && region_set !== 1'b0)
				report_mismatch("region_set", region_set, 1'b0);
			if (a == `MD_HDR_END + 2) begin
				if (region_set !== row.exp_set)
					report_mismatch("region_set", region_set, row.exp_set);
				if (row.exp_set && region_req !== row.exp_req)
					report_mismatch("region_req", region_req, row.exp_req);
			end
		end
		ld_wr         = 1'b0;
		cart_download = 1'b0;
		idle_cycles(2);
		if (rom_size !== row.rom_end)
			report_mismatch("rom_size", rom_size, row.rom_end);
		if (region_set !== 1'b0)
			report_mismatch("region_set", region_set, 1'b0);
		if (quirks !== row.exp_quirks)
			report_mismatch("quirks", quirks, row.exp_quirks); // Sticky past the end
	endtask

	task automatic run_cheat(input cheat_row_t row);
		logic [`MD_ADDR_W-1:0] addr;
		code_download = 1'b1;
		idle_cycles(1);
		for (int k = 0; k < 8; k++) begin
			addr = row.base + 25'(2 * k);
			write_word(addr, row.words[16*k +: 16]);
			if (gg_reset !== (addr == '0))
				report_mismatch("gg_reset", gg_reset, addr == '0);
			if (gg_code_stb !== (k == 7))
				report_mismatch("gg_code_stb", gg_code_stb, k == 7);
		end
		if (gg_code !== row.exp_code)
			report_mismatch("gg_code", gg_code, row.exp_code);
		ld_wr = 1'b0;
		idle_cycles(1);
		if (gg_code_stb !== 1'b0)
			report_mismatch("gg_code_stb", gg_code_stb, 1'b0); // Single pulse only
		code_download = 0;
		idle_cycles(1);
	endtask

	//////////////////////////////////////////////////////////////////////
	initial begin
		void'($urandom(57));
		errors        = 0;
		clk_sys       = 1'b0;
		RESET         = 1'b1;
		cart_download = 1'b0;
		code_download = 1'b0;
		ld_wr         = 1'b0;
		ld_addr       = '0;
		ld_data       = '0;
		region_auto   = 1'b0;
		region_prio   = 2'd0;
		repeat (5) @(posedge clk_sys);
		#2;
		RESET = 1'b0;
		if (region_set !== 1'b0)
			report_mismatch("region_set", region_set, 1'b0);
		if (quirks !== 7'h00)
			report_mismatch("quirks", quirks, 7'h00);
		if (gg_code_stb !== 1'b0 || gg_reset !== 1'b0)
			report_mismatch("{gg_code_stb, gg_reset}", {gg_code_stb, gg_reset}, 2'b00);
		if (rom_size !== '0)
			report_mismatch("rom_size", rom_size, 0);
		foreach (CARTS[i])
			run_cart(CARTS[i]);
		foreach (CHEATS[i])
			run_cheat(CHEATS[i]);
		$display("Cartridges %0d, cheat records %0d, errors %0d", 10, 3, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	// Watchdog
	initial begin
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge clk_sys);
			cycle_count++;
		end
		$display("Timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Regression failed");
		$finish;
	end

endmodule
